// ==== logic/asg_types_pkg.sv ====
// ASG channel data types and register map
// sample, amplitude, count and bus word widths plus CTRL bit positions

package asg_types_pkg;

  typedef logic signed [13:0] sample_t;   // DAC / table sample
  typedef logic        [13:0] amp_t;      // 0x2000 is unity gain
  typedef logic        [15:0] cnt16_t;    // cycle and repetition counts
  typedef logic        [31:0] dly_t;      // delay in us ticks
  typedef logic        [31:0] wb_data_t;  // Wishbone data word

  localparam int PNT_FRAC = 16;           // pointer fraction bits

  // register word indices
  localparam int REG_CTRL = 0;
  localparam int REG_SIZE = 1;
  localparam int REG_STEP = 2;
  localparam int REG_OFS  = 3;
  localparam int REG_AMP  = 4;
  localparam int REG_DC   = 5;
  localparam int REG_LAST = 6;
  localparam int REG_NCYC = 7;
  localparam int REG_RNUM = 8;
  localparam int REG_RDLY = 9;
  localparam int REG_RPNT = 10;           // read only

  // CTRL bit positions
  localparam int CTRL_RST    = 0;
  localparam int CTRL_WRAP   = 1;
  localparam int CTRL_ZERO   = 2;
  localparam int CTRL_RGATE  = 3;
  localparam int CTRL_SRC_LO = 4;
  localparam int CTRL_SRC_HI = 6;
  localparam int CTRL_SWTRIG = 8;         // write-only pulse

  typedef enum logic [2:0] {
    TRIG_NONE    = 3'd0,
    TRIG_SW      = 3'd1,
    TRIG_EXT_POS = 3'd2,
    TRIG_EXT_NEG = 3'd3
  } trig_src_e;

endpackage

// ==== logic/asg_timing_pkg.sv ====
// ASG channel sequencing definitions
// burst FSM states and default timing constants

package asg_timing_pkg;

  typedef enum logic [1:0] {
    ST_IDLE,   // waiting for trigger
    ST_RUN,    // stepping through table
    ST_HOLD    // burst done, waiting for repeat
  } burst_state_e;

  localparam int DEF_TICK_DIV = 125;    // cycles per us at 125 MHz
  localparam int DEF_DEBOUNCE = 62500;  // ~0.5 ms lockout
  localparam int DLY_PIPE     = 4;      // pointer to dac_o latency

endpackage

// ==== logic/asg_cfg_if.sv ====
// ASG channel configuration bundle
// register block drives it, sequencer and output stage read it

interface asg_cfg_if #(
  parameter int RSZ = 14
);
  import asg_types_pkg::*;

  typedef logic [RSZ+PNT_FRAC-1:0] pnt_t;

  pnt_t      size, step, ofs;     // fixed point table geometry
  logic      wrap, rst, zero, rgate;
  trig_src_e src;
  logic      sw_trig;             // one-cycle pulse
  cnt16_t    ncyc, rnum;
  dly_t      rdly;
  amp_t      amp;
  sample_t   dc, last;

  modport regs (output size, step, ofs, wrap, rst, zero, rgate, src, sw_trig,
                       ncyc, rnum, rdly, amp, dc, last);
  modport seq  (input  size, step, ofs, wrap, rst, zero, rgate, src, sw_trig,
                       ncyc, rnum, rdly);
  modport out  (input  amp, dc, last, zero);

endinterface

// ==== logic/asg_wb_regs.sv ====
// ASG Wishbone classic slave
// config registers, sample table write port, single-cycle ack

module asg_wb_regs #(
  parameter int RSZ = 14
) (
  input  logic                     dac_clk_i,
  input  logic                     dac_rstn_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [RSZ:0]             wb_adr_i,   // word address, msb selects table
  input  asg_types_pkg::wb_data_t  wb_dat_i,
  output asg_types_pkg::wb_data_t  wb_dat_o,
  output logic                     wb_ack_o,
  input  logic [RSZ-1:0]           rpnt_i,
  output logic                     tbl_we_o,
  output logic [RSZ-1:0]           tbl_addr_o,
  output asg_types_pkg::sample_t   tbl_data_o,
  asg_cfg_if.regs                  cfg_o
);
  import asg_types_pkg::*;

  logic           active, wr_stb, tbl_sel, reg_wr;
  logic [RSZ-1:0] reg_idx;
  wb_data_t       rdat;

  assign active  = wb_cyc_i && wb_stb_i;
  assign wr_stb  = active && wb_we_i && !wb_ack_o;  // write lands on ack edge
  assign tbl_sel = wb_adr_i[RSZ];
  assign reg_idx = wb_adr_i[RSZ-1:0];
  assign reg_wr  = wr_stb && !tbl_sel;

  // table write port, straight off the bus
  assign tbl_we_o   = wr_stb && tbl_sel;
  assign tbl_addr_o = reg_idx;
  assign tbl_data_o = sample_t'(wb_dat_i[13:0]);

  // --------------------------------------------------
  // ack and register file
  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      wb_ack_o      <= 1'b0;
      cfg_o.sw_trig <= 1'b0;
      cfg_o.rst     <= 1'b0;
      cfg_o.wrap    <= 1'b0;
      cfg_o.zero    <= 1'b0;
      cfg_o.rgate   <= 1'b0;
      cfg_o.src     <= TRIG_NONE;
      cfg_o.size    <= '0;
      cfg_o.step    <= '0;
      cfg_o.ofs     <= '0;
      cfg_o.amp     <= '0;
      cfg_o.dc      <= '0;
      cfg_o.last    <= '0;
      cfg_o.ncyc    <= '0;
      cfg_o.rnum    <= '0;
      cfg_o.rdly    <= '0;
    end else begin
      wb_ack_o      <= active && !wb_ack_o;   // one cycle, no wait states
      cfg_o.sw_trig <= 1'b0;                  // self clearing
      if (reg_wr) begin
        case (reg_idx)
          RSZ'(REG_CTRL): begin
            cfg_o.rst     <= wb_dat_i[CTRL_RST];
            cfg_o.wrap    <= wb_dat_i[CTRL_WRAP];
            cfg_o.zero    <= wb_dat_i[CTRL_ZERO];
            cfg_o.rgate   <= wb_dat_i[CTRL_RGATE];
            cfg_o.src     <= trig_src_e'(wb_dat_i[CTRL_SRC_HI:CTRL_SRC_LO]);
            cfg_o.sw_trig <= wb_dat_i[CTRL_SWTRIG];
          end
          RSZ'(REG_SIZE): cfg_o.size <= wb_dat_i[RSZ+PNT_FRAC-1:0];
          RSZ'(REG_STEP): cfg_o.step <= wb_dat_i[RSZ+PNT_FRAC-1:0];
          RSZ'(REG_OFS):  cfg_o.ofs  <= wb_dat_i[RSZ+PNT_FRAC-1:0];
          RSZ'(REG_AMP):  cfg_o.amp  <= wb_dat_i[13:0];
          RSZ'(REG_DC):   cfg_o.dc   <= sample_t'(wb_dat_i[13:0]);
          RSZ'(REG_LAST): cfg_o.last <= sample_t'(wb_dat_i[13:0]);
          RSZ'(REG_NCYC): cfg_o.ncyc <= wb_dat_i[15:0];
          RSZ'(REG_RNUM): cfg_o.rnum <= wb_dat_i[15:0];
          RSZ'(REG_RDLY): cfg_o.rdly <= wb_dat_i;
          default: ;                          // rpnt and holes ignore writes
        endcase
      end
    end
  end

  // --------------------------------------------------
  // read mux, table region reads as zero
  always_comb begin
    rdat = '0;
    if (!tbl_sel) begin
      case (reg_idx)
        RSZ'(REG_CTRL): begin
          rdat[CTRL_RST]                 = cfg_o.rst;
          rdat[CTRL_WRAP]                = cfg_o.wrap;
          rdat[CTRL_ZERO]                = cfg_o.zero;
          rdat[CTRL_RGATE]               = cfg_o.rgate;
          rdat[CTRL_SRC_HI:CTRL_SRC_LO]  = cfg_o.src;
        end
        RSZ'(REG_SIZE): rdat = 32'(cfg_o.size);
        RSZ'(REG_STEP): rdat = 32'(cfg_o.step);
        RSZ'(REG_OFS):  rdat = 32'(cfg_o.ofs);
        RSZ'(REG_AMP):  rdat = 32'(cfg_o.amp);
        RSZ'(REG_DC):   rdat = 32'($unsigned(cfg_o.dc));
        RSZ'(REG_LAST): rdat = 32'($unsigned(cfg_o.last));
        RSZ'(REG_NCYC): rdat = 32'(cfg_o.ncyc);
        RSZ'(REG_RNUM): rdat = 32'(cfg_o.rnum);
        RSZ'(REG_RDLY): rdat = cfg_o.rdly;
        RSZ'(REG_RPNT): rdat = 32'(rpnt_i);   // live pointer index
        default:        rdat = '0;
      endcase
    end
  end

  always_ff @(posedge dac_clk_i) begin
    if (active && !wb_ack_o)
      wb_dat_o <= rdat;   // valid with ack
  end

endmodule

// ==== logic/asg_ext_trig.sv ====
// ASG external trigger input
// 3-flop synchronizer, per-edge lockout debounce, edge pulses

module asg_ext_trig #(
  parameter int DEBOUNCE = asg_timing_pkg::DEF_DEBOUNCE
) (
  input  logic dac_clk_i,
  input  logic dac_rstn_i,
  input  logic trig_ext_i,
  output logic ext_pos_o,   // accepted rising edge
  output logic ext_neg_o    // accepted falling edge
);

  localparam int CW = $clog2(DEBOUNCE + 1);

  logic [2:0]    sync;            // sync chain, [2] oldest
  logic [1:0]    edge_seen;       // [0] rise, [1] fall
  logic [CW-1:0] lock [2];        // lockout per direction
  logic [1:0]    lvl  [2];        // sampled level history

  assign edge_seen[0] =  sync[1] && !sync[2];
  assign edge_seen[1] = !sync[1] &&  sync[2];

  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      sync <= '0;
      for (int i = 0; i < 2; i++) begin
        lock[i] <= '0;
        lvl[i]  <= '0;
      end
    end else begin
      sync <= {sync[1:0], trig_ext_i};
      for (int i = 0; i < 2; i++) begin
        // start lockout on the first edge, ignore bounces after it
        if (lock[i] == '0 && edge_seen[i])
          lock[i] <= CW'(DEBOUNCE);
        else if (lock[i] != '0)
          lock[i] <= lock[i] - 1'b1;
        lvl[i][1] <= lvl[i][0];
        if (lock[i] == '0)
          lvl[i][0] <= sync[1];   // frozen while locked
      end
    end
  end

  assign ext_pos_o = (lvl[0] == 2'b01);
  assign ext_neg_o = (lvl[1] == 2'b10);

endmodule

// ==== logic/asg_burst_fsm.sv ====
// ASG channel sequencer
// trigger select, burst/repeat FSM, delay ticks, fixed point read pointer
// and last-value hold timing

module asg_burst_fsm #(
  parameter int RSZ      = 14,
  parameter int TICK_DIV = asg_timing_pkg::DEF_TICK_DIV
) (
  input  logic           dac_clk_i,
  input  logic           dac_rstn_i,
  input  logic           ext_pos_i,
  input  logic           ext_neg_i,
  input  logic           trig_ext_i,    // raw level, for gated repeats
  asg_cfg_if.seq         cfg_i,
  output logic [RSZ-1:0] rd_idx_o,
  output logic           hold_last_o,
  output logic           trig_done_o
);
  import asg_types_pkg::*;
  import asg_timing_pkg::*;

  typedef logic [RSZ+PNT_FRAC-1:0] pnt_t;

  localparam int            TW        = $clog2(TICK_DIV + 1);
  localparam logic [TW-1:0] TICK_LAST = TW'(TICK_DIV - 1);

  burst_state_e          state;
  pnt_t                  pnt, pnt_prev;
  logic [RSZ+PNT_FRAC:0] npnt, npnt_sub;   // one extra bit for the sign
  logic                  past_end, run, trig_in, dac_trig, start;
  logic                  rep_on, trig_r, not_burst, gate_off;
  cnt16_t                cyc_cnt, rep_cnt;
  dly_t                  dly_cnt;
  logic [TW-1:0]         tick;
  logic [DLY_PIPE-2:0]   run_sr;           // run history for hold alignment

  assign run       = (state == ST_RUN);
  assign npnt      = {1'b0, pnt} + {1'b0, cfg_i.step};
  assign npnt_sub  = npnt - {1'b0, cfg_i.size} - 1'b1;
  assign past_end  = !npnt_sub[RSZ+PNT_FRAC];   // next step beyond size
  assign dac_trig  = (!rep_on && trig_in) || (rep_on && |rep_cnt && dly_cnt == '0);
  assign start     = dac_trig && !run;
  assign not_burst = (cfg_i.ncyc == '0) && (cfg_i.rnum == '0);   // continuous
  assign gate_off  = (cfg_i.src == TRIG_EXT_POS && !trig_ext_i) ||
                     (cfg_i.src == TRIG_EXT_NEG &&  trig_ext_i);
  assign rd_idx_o  = pnt[RSZ+PNT_FRAC-1:PNT_FRAC];

  // --------------------------------------------------
  // trigger select, FSM and counters
  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      state       <= ST_IDLE;
      trig_in     <= 1'b0;
      trig_done_o <= 1'b0;
      trig_r      <= 1'b0;
      rep_on      <= 1'b0;
      cyc_cnt     <= '0;
      rep_cnt     <= '0;
      dly_cnt     <= '0;
      tick        <= '0;
      pnt         <= '0;
      pnt_prev    <= '0;
    end else begin
      case (cfg_i.src)
        TRIG_SW:      trig_in <= cfg_i.sw_trig;
        TRIG_EXT_POS: trig_in <= ext_pos_i;
        TRIG_EXT_NEG: trig_in <= ext_neg_i;
        default:      trig_in <= 1'b0;
      endcase
      trig_done_o <= start && !cfg_i.rst;   // one pulse per burst start

      if (cfg_i.rst)
        state <= ST_IDLE;
      else begin
        case (state)
          ST_IDLE: if (dac_trig) state <= ST_RUN;
          ST_RUN:  if (!dac_trig && cyc_cnt == 16'd1 && past_end) state <= ST_HOLD;
          ST_HOLD: if (dac_trig) state <= ST_RUN;
          default: state <= ST_IDLE;
        endcase
      end

      // repetition mode flag
      if (dac_trig && !cfg_i.rst)
        rep_on <= 1'b1;
      else if (cfg_i.rst || rep_cnt == '0)
        rep_on <= 1'b0;

      // 1 us tick, restarted by each run
      if (run || tick == TICK_LAST)
        tick <= '0;
      else
        tick <= tick + 1'b1;

      // delay between repeats
      if (cfg_i.rst || run)
        dly_cnt <= cfg_i.rdly;
      else if (|dly_cnt && tick == TICK_LAST)
        dly_cnt <= dly_cnt - 1'b1;

      // repeats left, loaded on the first trigger
      if (trig_in && !run)
        rep_cnt <= cfg_i.rnum;
      else if (!cfg_i.rgate && |rep_cnt && rep_on && start)
        rep_cnt <= rep_cnt - 1'b1;
      else if (cfg_i.rgate && gate_off)
        rep_cnt <= '0;

      // table passes, a pass ends when the pointer goes backwards
      pnt_prev <= pnt;
      trig_r   <= dac_trig;
      if (dac_trig)
        cyc_cnt <= cfg_i.ncyc;
      else if (!trig_r && |cyc_cnt && (pnt_prev > pnt))
        cyc_cnt <= cyc_cnt - 1'b1;

      // read pointer
      if (cfg_i.rst || start)
        pnt <= cfg_i.ofs;
      else if (run) begin
        if (!past_end)
          pnt <= npnt[RSZ+PNT_FRAC-1:0];
        else if (cfg_i.wrap)
          pnt <= npnt_sub[RSZ+PNT_FRAC-1:0];   // keep fraction across wrap
        else
          pnt <= cfg_i.ofs;
      end
    end
  end

  // --------------------------------------------------
  // last value hold, lined up with the output pipe
  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      run_sr      <= '0;
      hold_last_o <= 1'b0;
    end else begin
      run_sr <= {run_sr[DLY_PIPE-3:0], run};
      if ((hold_last_o && dly_cnt == '0 && |rep_cnt) || cfg_i.zero ||
          cfg_i.rst || not_burst)
        hold_last_o <= 1'b0;                   // next repeat or mode change
      else if (run_sr[DLY_PIPE-2] && !run_sr[DLY_PIPE-3])
        hold_last_o <= 1'b1;                   // end of run reached the mux
    end
  end

endmodule

// ==== logic/asg_table_out.sv ====
// ASG sample table and output stage
// RAM read, amplitude scale, dc offset, saturation, zero / last select

module asg_table_out #(
  parameter int RSZ = 14
) (
  input  logic                   dac_clk_i,
  input  logic                   dac_rstn_i,
  input  logic                   tbl_we_i,
  input  logic [RSZ-1:0]         tbl_addr_i,
  input  asg_types_pkg::sample_t tbl_data_i,
  input  logic [RSZ-1:0]         rd_idx_i,
  input  logic                   hold_last_i,
  asg_cfg_if.out                 cfg_i,
  output asg_types_pkg::sample_t dac_o
);
  import asg_types_pkg::*;

  sample_t            ram [2**RSZ];   // sample table
  sample_t            rd;             // stage 1
  logic signed [28:0] prod;
  logic signed [27:0] mult;           // stage 2
  logic signed [14:0] sum;            // stage 3
  logic               ovf;
  sample_t            sat;

  assign prod = rd * $signed({1'b0, cfg_i.amp});   // amp is unsigned
  assign ovf  = sum[14] ^ sum[13];
  assign sat  = ovf ? {sum[14], {13{~sum[14]}}} : sum[13:0];   // 0x1FFF / 0x2000

  // --------------------------------------------------
  // table and datapath, no reset
  always_ff @(posedge dac_clk_i) begin
    if (tbl_we_i)
      ram[tbl_addr_i] <= tbl_data_i;
    rd   <= ram[rd_idx_i];
    mult <= prod[27:0];
    sum  <= $signed(mult[27:13]) + $signed({cfg_i.dc[13], cfg_i.dc});
  end

  // --------------------------------------------------
  // output register
  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i)
      dac_o <= '0;
    else if (cfg_i.zero)
      dac_o <= '0;                 // forced zero wins
    else if (hold_last_i)
      dac_o <= cfg_i.last;         // burst finished
    else
      dac_o <= sat;
  end

endmodule

// ==== logic/asg_top.sv ====
// ASG single channel top level
// Wishbone register slave, trigger input, sequencer and DAC output stage

module asg_top #(
  parameter int RSZ      = 14,
  parameter int TICK_DIV = asg_timing_pkg::DEF_TICK_DIV,
  parameter int DEBOUNCE = asg_timing_pkg::DEF_DEBOUNCE
) (
  input  logic                    dac_clk_i,
  input  logic                    dac_rstn_i,
  // Wishbone classic slave
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [RSZ:0]            wb_adr_i,
  input  asg_types_pkg::wb_data_t wb_dat_i,
  output asg_types_pkg::wb_data_t wb_dat_o,
  output logic                    wb_ack_o,
  // trigger and DAC
  input  logic                    trig_ext_i,
  output logic                    trig_done_o,
  output asg_types_pkg::sample_t  dac_o
);

  logic                   tbl_we, hold_last, ext_pos, ext_neg;
  logic [RSZ-1:0]         tbl_addr, rd_idx;
  asg_types_pkg::sample_t tbl_data;

  asg_cfg_if #(.RSZ(RSZ)) cfg ();

  asg_wb_regs #(.RSZ(RSZ)) u_regs (
    .dac_clk_i, .dac_rstn_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .rpnt_i     (rd_idx),
    .tbl_we_o   (tbl_we),
    .tbl_addr_o (tbl_addr),
    .tbl_data_o (tbl_data),
    .cfg_o      (cfg.regs)
  );

  asg_ext_trig #(.DEBOUNCE(DEBOUNCE)) u_ext_trig (
    .dac_clk_i, .dac_rstn_i, .trig_ext_i,
    .ext_pos_o (ext_pos),
    .ext_neg_o (ext_neg)
  );

  asg_burst_fsm #(.RSZ(RSZ), .TICK_DIV(TICK_DIV)) u_fsm (
    .dac_clk_i, .dac_rstn_i, .trig_ext_i, .trig_done_o,
    .ext_pos_i   (ext_pos),
    .ext_neg_i   (ext_neg),
    .cfg_i       (cfg.seq),
    .rd_idx_o    (rd_idx),
    .hold_last_o (hold_last)
  );

  asg_table_out #(.RSZ(RSZ)) u_out (
    .dac_clk_i, .dac_rstn_i, .dac_o,
    .tbl_we_i    (tbl_we),
    .tbl_addr_i  (tbl_addr),
    .tbl_data_i  (tbl_data),
    .rd_idx_i    (rd_idx),
    .hold_last_i (hold_last),
    .cfg_i       (cfg.out)
  );

endmodule

// ==== bench/asg_tb.sv ====
// ASG channel testbench
// register readback, continuous playback, dc and saturation, zero,
// burst with repeats and debounced external trigger

module asg_tb;
  import asg_types_pkg::*;

  localparam int RSZ     = 4;                       // 16 table entries
  localparam int T_REGS  = 300;                     // per-test cycle budgets
  localparam int T_PLAY  = 700;
  localparam int T_BURST = 600;
  localparam int T_EXT   = 400;
  localparam int WD_CYCLES = 2 * (T_REGS + T_PLAY + T_BURST + T_EXT);
  localparam int LAST_V  = 291;                     // 0x123, burst end value

  logic         dac_clk_i, dac_rstn_i;
  logic         wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [RSZ:0] wb_adr_i;
  wb_data_t     wb_dat_i, wb_dat_o;
  logic         trig_ext_i, trig_done_o;
  sample_t      dac_o;

  int     tbl_ref [16];               // expected table contents
  int     mism_cnt = 0;
  int     fail_cnt = 0;
  int     trig_cnt = 0;               // trig_done_o pulses seen
  int     since = 1000000;            // cycles since last trig_done_o
  int     dc_cur = 0;
  int     play_len = 0;               // samples to check, 0 = forever
  logic   play_chk = 1'b0;
  logic   ack_exp;
  string  play_name = "playback";
  integer seed;

  asg_top #(.RSZ(RSZ), .TICK_DIV(4), .DEBOUNCE(16)) uut (.*);

  initial dac_clk_i = 1'b0;
  always #50 dac_clk_i = ~dac_clk_i;

  function automatic int clamp14(input int v);
    if (v > 8191) return 8191;        // 0x1FFF
    if (v < -8192) return -8192;      // 0x2000
    return v;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    mism_cnt++;
    $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
  endtask

  // --------------------------------------------------
  // Wishbone master, one request until ack
  task automatic wb_access(input logic we, input logic [RSZ:0] adr,
                           input wb_data_t dat, output wb_data_t rdat);
    int n;
    n = 0;
    @(negedge dac_clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    @(negedge dac_clk_i);
    while (!wb_ack_o && n < 8) begin
      @(negedge dac_clk_i);
      n++;
    end
    if (!wb_ack_o) begin
      fail_cnt++;
      $display("no wishbone ack for address 0x%0h", adr);
    end
    rdat     = wb_dat_o;             // valid while ack is high
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic reg_write(input int idx, input wb_data_t val);
    wb_data_t dummy;
    wb_access(1'b1, idx[RSZ:0], val, dummy);
  endtask

  task automatic read_expect(input logic [RSZ:0] adr, input wb_data_t exp_v);
    wb_data_t rdat;
    wb_access(1'b0, adr, '0, rdat);
    assert (rdat == exp_v) else
      report_mismatch($sformatf("readback 0x%0h", adr), exp_v, rdat);
  endtask

  task automatic reg_roundtrip(input int idx, input wb_data_t val);
    reg_write(idx, val);
    read_expect(idx[RSZ:0], val);
  endtask

  task automatic wait_pulses(input int target, input int limit);
    int n;
    n = 0;
    while (trig_cnt < target && n < limit) begin
      @(negedge dac_clk_i);
      n++;
    end
    if (trig_cnt < target) begin
      fail_cnt++;
      $display("timed out waiting for trigger pulse %0d, saw %0d", target, trig_cnt);
    end
  endtask

  task automatic set_dc(input sample_t v);
    play_chk = 1'b0;                 // dc changes mid pipe
    reg_write(REG_DC, 32'(v));
    dc_cur = v;
    repeat (4) @(negedge dac_clk_i);
    play_chk = 1'b1;
    repeat (20) @(negedge dac_clk_i);
  endtask

  // --------------------------------------------------
  // monitors
  always @(posedge dac_clk_i) begin
    if (!dac_rstn_i)
      ack_exp <= 1'b0;
    else begin
      assert (wb_ack_o == ack_exp) else report_mismatch("wishbone ack", ack_exp, wb_ack_o);
      ack_exp <= wb_cyc_i && wb_stb_i && !ack_exp;    // one cycle after request
    end
  end

  always @(posedge dac_clk_i) begin : play_check
    int exp_v;
    if (trig_done_o) begin
      since = 0;
      trig_cnt++;
    end else if (since < 1000000)
      since = since + 1;
    // output trails the pointer by 4 stages
    if (play_chk && since >= 4 && (play_len == 0 || since < 4 + play_len)) begin
      exp_v = clamp14(tbl_ref[(since - 4) % 16] + dc_cur);
      assert (int'(dac_o) == exp_v) else report_mismatch(play_name, exp_v, dac_o);
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge dac_clk_i);
    $display("timeout, run did not finish within %0d cycles", WD_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // --------------------------------------------------
  // stimulus
  initial begin
    sample_t dc_val;
    seed       = 32'h7e9d;
    dac_rstn_i = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    trig_ext_i = 1'b0;
    repeat (10) @(negedge dac_clk_i);
    // output state while reset is applied
    assert (wb_ack_o == 1'b0) else report_mismatch("reset ack", 0, wb_ack_o);
    assert (trig_done_o == 1'b0) else report_mismatch("reset trig_done", 0, trig_done_o);
    assert (dac_o == '0) else report_mismatch("reset dac", 0, dac_o);
    dac_rstn_i = 1'b1;
    @(negedge dac_clk_i);

    for (int k = 0; k < 16; k++) begin
      tbl_ref[k] = 100 * k - 700;
      reg_write(16 + k, 32'(tbl_ref[k]));   // msb set, table region
    end

    // register readback, rst held so pointer sits at ofs
    reg_roundtrip(REG_CTRL, 32'h0000_000F);
    reg_roundtrip(REG_SIZE, 32'h000A_BCDE);
    reg_roundtrip(REG_STEP, 32'h0001_2345);
    reg_roundtrip(REG_OFS,  32'h0003_5678);
    reg_roundtrip(REG_AMP,  32'h0000_1ABC);
    reg_roundtrip(REG_DC,   32'h0000_2345);
    reg_roundtrip(REG_LAST, 32'h0000_0123);
    reg_roundtrip(REG_NCYC, 32'h0000_BEEF);
    reg_roundtrip(REG_RNUM, 32'h0000_1234);
    reg_roundtrip(REG_RDLY, 32'hDEAD_BEEF);
    read_expect(REG_RPNT, 32'h3);            // ofs integer part
    read_expect(5'h13, 32'h0);               // table not readable

    // continuous playback
    reg_write(REG_SIZE, 32'h000F_FFFF);      // 16 entries, wrap to 0
    reg_write(REG_STEP, 32'h0001_0000);
    reg_write(REG_OFS,  32'h0);
    reg_write(REG_AMP,  32'h2000);           // unity gain
    reg_write(REG_DC,   32'h0);
    reg_write(REG_NCYC, 32'h0);
    reg_write(REG_RNUM, 32'h0);
    reg_write(REG_RDLY, 32'h0);
    trig_cnt = 0;
    reg_write(REG_CTRL, 32'h112);            // wrap, src sw, sw trigger
    wait_pulses(1, 20);
    play_chk = 1'b1;
    repeat (48) @(negedge dac_clk_i);
    assert (trig_cnt == 1) else report_mismatch("playback trigger count", 1, trig_cnt);

    // dc offset, two saturating plus two random
    play_name = "dc offset";
    set_dc(14'sd7936);
    set_dc(-14'sd8000);
    repeat (2) begin
      dc_val = sample_t'($random(seed));
      set_dc(dc_val);
    end
    play_chk = 1'b0;
    reg_write(REG_CTRL, 32'h16);             // force zero
    repeat (4) @(negedge dac_clk_i);
    assert (dac_o == '0) else report_mismatch("forced zero", 0, dac_o);

    // burst, 2 passes, 2 repeats, 1 tick delay
    reg_write(REG_CTRL, 32'h13);             // channel reset
    reg_write(REG_DC, 32'h0);
    dc_cur = 0;
    reg_write(REG_NCYC, 32'd2);
    reg_write(REG_RNUM, 32'd2);
    reg_write(REG_RDLY, 32'd1);
    reg_write(REG_LAST, 32'(LAST_V));
    play_name = "burst";
    play_len  = 32;                          // ncyc passes of 16
    play_chk  = 1'b1;
    trig_cnt  = 0;
    reg_write(REG_CTRL, 32'h112);
    wait_pulses(3, T_BURST);
    for (int n = 0; n < 80 && dac_o != sample_t'(LAST_V); n++)
      @(negedge dac_clk_i);
    repeat (60) begin
      @(negedge dac_clk_i);
      assert (dac_o == sample_t'(LAST_V)) else report_mismatch("burst hold", LAST_V, dac_o);
    end
    assert (trig_cnt == 3) else report_mismatch("burst trigger count", 3, trig_cnt);

    // external rising edge with bounces, one pass per trigger
    play_chk = 1'b0;
    reg_write(REG_CTRL, 32'h23);             // reset, src ext_pos
    reg_write(REG_STEP, 32'h0008_0000);      // half the table per step
    reg_write(REG_NCYC, 32'd1);
    reg_write(REG_RNUM, 32'd0);
    reg_write(REG_CTRL, 32'h22);
    trig_cnt = 0;
    trig_ext_i = 1'b1;
    repeat (3) @(negedge dac_clk_i);
    trig_ext_i = 1'b0;                       // bounce inside lockout
    repeat (2) @(negedge dac_clk_i);
    trig_ext_i = 1'b1;
    repeat (40) @(negedge dac_clk_i);
    assert (trig_cnt == 1) else report_mismatch("ext rising edge", 1, trig_cnt);
    trig_ext_i = 1'b0;                       // clean fall, wrong polarity
    repeat (40) @(negedge dac_clk_i);
    assert (trig_cnt == 1) else report_mismatch("ext falling edge", 1, trig_cnt);

    $display("checks done, %0d mismatches, %0d other errors", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/asg_types_pkg.sv
logic/asg_timing_pkg.sv
logic/asg_cfg_if.sv
logic/asg_wb_regs.sv
logic/asg_ext_trig.sv
logic/asg_burst_fsm.sv
logic/asg_table_out.sv
logic/asg_top.sv
bench/asg_tb.sv

// ==== Bender.yml ====
package:
  name: asg_channel

sources:
  - logic/asg_types_pkg.sv
  - logic/asg_timing_pkg.sv
  - logic/asg_cfg_if.sv
  - logic/asg_wb_regs.sv
  - logic/asg_ext_trig.sv
  - logic/asg_burst_fsm.sv
  - logic/asg_table_out.sv
  - logic/asg_top.sv
  - target: test
    files:
      - bench/asg_tb.sv
